//--- include/bpu_defines.svh
// Sizing macros for the gshare predictor; QUEUE_DEPTH must be at least 2 and HIST_BITS below PC_BITS
`ifndef BPU_DEFINES_SVH
`define BPU_DEFINES_SVH

//////////////////////////////
// Predictor geometry
//////////////////////////////

// Width of the global history register and of the PHT index
// The PHT therefore holds 2^HIST_BITS two-bit counters
`define HIST_BITS 10

// Width of the branch PC presented by fetch
// The index hash takes PC bits HIST_BITS down to 1 and ignores bit 0
`define PC_BITS 32

//////////////////////////////
// Flow control
//////////////////////////////

// Entries in the prediction queue
// The predictor starts with this many credits, so the queue can never overflow
`define QUEUE_DEPTH 4

`endif

//--- design/bpuCtrlPkg.sv
// Counter encoding is fixed at 2 bits with the upper bit as the direction; do not reorder the enum
package bpuCtrlPkg;

  //////////////////////////////
  // Saturating counter states
  //////////////////////////////

  // Ordered so that stepping toward taken is an increment
  // The upper bit doubles as the predicted direction
  typedef enum logic [1:0] {
    strongNotTaken = 2'b00,
    weakNotTaken   = 2'b01,
    weakTaken      = 2'b10,
    strongTaken    = 2'b11
  } counterState;

  // Every PHT entry reads as this until it is first written
  localparam counterState counterInit = weakNotTaken;

  // Predicted direction of a counter where high means taken
  function automatic logic isTaken(counterState state);
    return state[1];
  endfunction

  // High when the counter sits at either saturation end
  function automatic logic isStrong(counterState state);
    return (state == strongTaken) || (state == strongNotTaken);
  endfunction

endpackage

//--- design/bpuDataPkg.sv
// Payload layouts depend on bpuCtrlPkg and the sizing macros; compile bpuCtrlPkg first
`include "bpu_defines.svh"

package bpuDataPkg;

  //////////////////////////////
  // Fetch side request
  //////////////////////////////

  // A lookup only carries the branch PC
  // History is held inside the predictor and is not part of the request
  typedef struct packed {
    logic [`PC_BITS-1:0] pc;
  } lookupReq;

  //////////////////////////////
  // In-flight prediction
  //////////////////////////////

  // What the predictor shows on its output and what the queue stores
  // The index is kept so the resolver can write back without rehashing
  // The counter is the value the prediction was made from
  typedef struct packed {
    logic [`HIST_BITS-1:0]   index;
    bpuCtrlPkg::counterState counter;
  } predEntry;

  //////////////////////////////
  // Write back to the PHT
  //////////////////////////////

  // Produced by the resolver on every accepted outcome
  // Counter is the already stepped value to store at index
  // Taken is the outcome that shifts into the global history
  // Total size is HIST_BITS + 4 bits
  typedef struct packed {
    logic                    valid;
    logic [`HIST_BITS-1:0]   index;
    bpuCtrlPkg::counterState counter;
    logic                    taken;
  } phtUpdate;

endpackage

//--- design/phtRam.sv
// Read data lags the address by one cycle and a same-cycle write to the read index returns old data
`timescale 1ns/1ps
`include "bpu_defines.svh"

module phtRam (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [`HIST_BITS-1:0]   readIndex,
  output bpuCtrlPkg::counterState readCounter,
  input  bpuDataPkg::phtUpdate    update
);

  localparam int Entries = 1 << `HIST_BITS;

  // Counters only hold meaningful data where the matching valid bit is set
  bpuCtrlPkg::counterState counterMem [Entries];
  logic [Entries-1:0]      entryValid;

  // Registered read path
  bpuCtrlPkg::counterState memData;
  logic                    readValid;

  // Valid bits are the only state cleared by reset
  // An entry becomes valid the first time the resolver writes it
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      entryValid <= '0;
      readValid  <= 1'b0;
    end else begin
      if (update.valid) begin
        entryValid[update.index] <= 1'b1;
      end
      readValid <= entryValid[readIndex];
    end
  end

  // Single write port and a synchronous read port
  // Reading and writing one address in the same cycle yields the old counter
  always_ff @(posedge clk) begin
    if (update.valid) begin
      counterMem[update.index] <= update.counter;
    end
    memData <= counterMem[readIndex];
  end

  // Entries never written since reset read as the initial counter
  assign readCounter = readValid ? memData : bpuCtrlPkg::counterInit;

endmodule

//--- design/gshareLookup.sv
// One lookup per cycle, history advances only at resolution and there is no stall or flush
`timescale 1ns/1ps
`include "bpu_defines.svh"

module gshareLookup (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  lookupValid,
  input  bpuDataPkg::lookupReq  lookup,
  output logic                  lookupReady,
  output logic                  predValid,
  output bpuDataPkg::predEntry  predOut,
  input  bpuDataPkg::phtUpdate  update,
  input  logic                  creditReturn
);

  localparam int CreditBits = $clog2(`QUEUE_DEPTH + 1);

  logic [`HIST_BITS-1:0]   history;
  logic [`HIST_BITS-1:0]   lookupIndex;
  logic                    accept;
  logic [CreditBits-1:0]   creditCount;

  // Index of the lookup now in the PHT read stage
  logic [`HIST_BITS-1:0]   predIndex;

  // Forwarding state captured alongside the PHT read
  logic                    fwdMatch;
  bpuCtrlPkg::counterState fwdCounter;
  bpuCtrlPkg::counterState ramCounter;

  //////////////////////////////
  // Index hash and handshake
  //////////////////////////////

  // Gshare hash of the current history with PC bits HIST_BITS down to 1
  // A lookup in the same cycle as a resolution still sees the old history
  assign lookupIndex = history ^ lookup.pc[`HIST_BITS:1];

  // Every accepted lookup will occupy one queue entry, so it needs a credit
  assign lookupReady = (creditCount != '0);
  assign accept      = lookupValid && lookupReady;

  //////////////////////////////
  // History and credits
  //////////////////////////////

  // Outcomes enter at the top and the oldest falls off bit 0
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      history <= '0;
    end else if (update.valid) begin
      history <= {update.taken, history[`HIST_BITS-1:1]};
    end
  end

  // A lookup and a returned credit in one cycle cancel out
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      creditCount <= CreditBits'(`QUEUE_DEPTH);
    end else begin
      case ({accept, creditReturn})
        2'b10:   creditCount <= creditCount - CreditBits'(1);
        2'b01:   creditCount <= creditCount + CreditBits'(1);
        default: creditCount <= creditCount;
      endcase
    end
  end

  //////////////////////////////
  // PHT read and forwarding
  //////////////////////////////

  // The RAM reads every cycle and the result only matters after an accept
  phtRam pht (
    .clk         (clk),
    .rstN        (rstN),
    .readIndex   (lookupIndex),
    .readCounter (ramCounter),
    .update      (update)
  );

  // A write landing on the index being read is invisible to the RAM read
  // so the match and the new counter are held for one cycle instead
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      predValid <= 1'b0;
      fwdMatch  <= 1'b0;
    end else begin
      predValid <= accept;
      fwdMatch  <= update.valid && (update.index == lookupIndex);
    end
  end

  // Index of the accepted lookup and the counter written in the same cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      predIndex <= lookupIndex;
    end
    fwdCounter <= update.counter;
  end

  // Prediction reflects any write made in the acceptance cycle
  assign predOut.index   = predIndex;
  assign predOut.counter = fwdMatch ? fwdCounter : ramCounter;

endmodule

//--- design/predictionQueue.sv
// Relies on credits upstream to never push when full; a pop on an empty queue is ignored
`timescale 1ns/1ps
`include "bpu_defines.svh"

module predictionQueue (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 push,
  input  bpuDataPkg::predEntry pushEntry,
  input  logic                 pop,
  output bpuDataPkg::predEntry headEntry,
  output logic                 notEmpty,
  output logic                 creditReturn
);

  localparam int PtrBits   = $clog2(`QUEUE_DEPTH);
  localparam int CountBits = $clog2(`QUEUE_DEPTH + 1);

  bpuDataPkg::predEntry entries [`QUEUE_DEPTH];
  logic [PtrBits-1:0]   wrPtr;
  logic [PtrBits-1:0]   rdPtr;
  logic [CountBits-1:0] count;
  logic                 doPop;

  // Wraps at QUEUE_DEPTH, which need not be a power of two
  function automatic logic [PtrBits-1:0] nextPtr(logic [PtrBits-1:0] ptr);
    logic [PtrBits-1:0] lastSlot;
    lastSlot = PtrBits'(`QUEUE_DEPTH - 1);
    return (ptr == lastSlot) ? '0 : ptr + PtrBits'(1);
  endfunction

  assign notEmpty  = (count != '0);
  assign doPop     = pop && notEmpty;
  assign headEntry = entries[rdPtr];

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      // Simultaneous push and pop leave the occupancy unchanged
      case ({push, doPop})
        2'b10:   count <= count + CountBits'(1);
        2'b01:   count <= count - CountBits'(1);
        default: count <= count;
      endcase
    end
  end

  // Each pushed prediction lands in the slot the write pointer names
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wrPtr] <= pushEntry;
    end
  end

  //////////////////////////////
  // Credit return
  //////////////////////////////

  // Each retired entry sends one pulse a cycle after its pop
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      creditReturn <= 1'b0;
    end else begin
      creditReturn <= doPop;
    end
  end

endmodule

//--- design/branchResolver.sv
// Purely combinational, resolves strictly in order and expects outcomes only for queued predictions
`timescale 1ns/1ps

module branchResolver (
  input  logic                 resolveValid,
  input  logic                 resolveTaken,
  input  bpuDataPkg::predEntry headEntry,
  input  logic                 notEmpty,
  output logic                 pop,
  output bpuDataPkg::phtUpdate update,
  output logic                 mispredict
);

  logic                    accept;
  bpuCtrlPkg::counterState nextCounter;

  // An outcome is only taken when there is a prediction to match it with
  assign accept = resolveValid && notEmpty;
  assign pop    = accept;

  // Move the stored counter one step toward the outcome
  // Both ends saturate
  always_comb begin
    case (headEntry.counter)
      bpuCtrlPkg::strongNotTaken:
        nextCounter = resolveTaken ? bpuCtrlPkg::weakNotTaken : bpuCtrlPkg::strongNotTaken;
      bpuCtrlPkg::weakNotTaken:
        nextCounter = resolveTaken ? bpuCtrlPkg::weakTaken : bpuCtrlPkg::strongNotTaken;
      bpuCtrlPkg::weakTaken:
        nextCounter = resolveTaken ? bpuCtrlPkg::strongTaken : bpuCtrlPkg::weakNotTaken;
      default:
        nextCounter = resolveTaken ? bpuCtrlPkg::strongTaken : bpuCtrlPkg::weakTaken;
    endcase
  end

  // Write back to the same index the prediction was read from
  assign update.valid   = accept;
  assign update.index   = headEntry.index;
  assign update.counter = nextCounter;
  assign update.taken   = resolveTaken;

  // Compare against the counter the prediction used, not the updated one
  assign mispredict = accept && (bpuCtrlPkg::isTaken(headEntry.counter) != resolveTaken);

endmodule

//--- design/bpuTop.sv
// Lookup to prediction is one cycle; resolution writes the PHT and history at the next edge
`timescale 1ns/1ps

module bpuTop (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 lookupValid,
  input  bpuDataPkg::lookupReq lookup,
  output logic                 lookupReady,
  output logic                 predValid,
  output bpuDataPkg::predEntry predOut,
  input  logic                 resolveValid,
  input  logic                 resolveTaken,
  output logic                 resolveReady,
  output logic                 mispredict
);

  bpuDataPkg::phtUpdate update;
  bpuDataPkg::predEntry headEntry;
  logic                 pop;
  logic                 creditReturn;

  //////////////////////////////
  // Producer
  //////////////////////////////

  gshareLookup predictor (
    .clk          (clk),
    .rstN         (rstN),
    .lookupValid  (lookupValid),
    .lookup       (lookup),
    .lookupReady  (lookupReady),
    .predValid    (predValid),
    .predOut      (predOut),
    .update       (update),
    .creditReturn (creditReturn)
  );

  //////////////////////////////
  // Buffer
  //////////////////////////////

  // Every prediction is parked here until its outcome arrives
  // A non-empty queue is exactly when the execute side may resolve
  predictionQueue queue (
    .clk          (clk),
    .rstN         (rstN),
    .push         (predValid),
    .pushEntry    (predOut),
    .pop          (pop),
    .headEntry    (headEntry),
    .notEmpty     (resolveReady),
    .creditReturn (creditReturn)
  );

  //////////////////////////////
  // Consumer
  //////////////////////////////

  branchResolver resolver (
    .resolveValid (resolveValid),
    .resolveTaken (resolveTaken),
    .headEntry    (headEntry),
    .notEmpty     (resolveReady),
    .pop          (pop),
    .update       (update),
    .mispredict   (mispredict)
  );

endmodule

//--- tests/bpuChecker.sv
// Reference model samples every port on the falling edge, when inputs and outputs have settled
`timescale 1ns/1ps
`include "bpu_defines.svh"

module bpuChecker (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 lookupValid,
  input  bpuDataPkg::lookupReq lookup,
  input  logic                 lookupReady,
  input  logic                 predValid,
  input  bpuDataPkg::predEntry predOut,
  input  logic                 resolveValid,
  input  logic                 resolveTaken,
  input  logic                 resolveReady,
  input  logic                 mispredict,
  output int                   errorCount,
  output int                   checkCount,
  output int                   forwardCount,
  output int                   satCount
);

  localparam int Entries = 1 << `HIST_BITS;

  int errors    = 0;
  int checks    = 0;
  int forwards  = 0;
  int saturated = 0;

  // Reference state with counters kept as plain 2-bit values
  logic [1:0]            modelPht [Entries];
  logic [`HIST_BITS-1:0] modelHist;
  bpuDataPkg::predEntry  modelQueue [$];
  int                    credits;
  logic                  creditDue;

  // Lookup accepted last cycle whose prediction is due now
  logic                  pendValid;
  bpuDataPkg::predEntry  pendEntry;

  assign errorCount   = errors;
  assign checkCount   = checks;
  assign forwardCount = forwards;
  assign satCount     = saturated;

  // One step toward the outcome and clamped to the range 0 to 3
  function automatic logic [1:0] stepCounter(logic [1:0] counter, logic taken);
    int level;
    level = taken ? int'(counter) + 1 : int'(counter) - 1;
    if (level > 3) begin
      level = 3;
    end
    if (level < 0) begin
      level = 0;
    end
    return level[1:0];
  endfunction

  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic reportFault(input string what);
    errors++;
    $display("%s", what);
  endtask

  //////////////////////////////
  // Per-cycle model step
  //////////////////////////////

  always @(negedge clk) begin : modelStep
    bpuDataPkg::predEntry  head;
    logic                  doResolve;
    logic                  doLookup;
    logic                  expMiss;
    logic [`HIST_BITS-1:0] rdIndex;
    int                    outstanding;
    if (rstN !== 1'b1) begin
      // Idle values while reset is held
      compareValue("resetPredValid", 0, 32'(predValid));
      compareValue("resetMispredict", 0, 32'(mispredict));
      compareValue("resetLookupReady", 1, 32'(lookupReady));
      compareValue("resetResolveReady", 0, 32'(resolveReady));
      // Every entry starts at weakNotTaken
      foreach (modelPht[i]) begin
        modelPht[i] = 2'b01;
      end
      modelHist = '0;
      modelQueue.delete();
      credits   = `QUEUE_DEPTH;
      creditDue = 1'b0;
      pendValid = 1'b0;
    end else begin
      // A prediction is due exactly one cycle after each acceptance
      compareValue("predValid", 32'(pendValid), 32'(predValid));
      if (predValid && pendValid) begin
        compareValue("predIndex", 32'(pendEntry.index), 32'(predOut.index));
        compareValue("predCounter", 32'(pendEntry.counter), 32'(predOut.counter));
      end
      compareValue("resolveReady", 32'(modelQueue.size() != 0), 32'(resolveReady));
      compareValue("lookupReady", 32'(credits != 0), 32'(lookupReady));

      // The write lands before this cycle's lookup reads the table
      doResolve = resolveValid && (modelQueue.size() != 0);
      expMiss   = 1'b0;
      if (doResolve) begin
        head    = modelQueue.pop_front();
        expMiss = (head.counter[1] != resolveTaken);
        // An outcome pushing a counter against its end has to leave it there
        if ((head.counter == 2'b11 && resolveTaken) ||
            (head.counter == 2'b00 && !resolveTaken)) begin
          saturated++;
        end
        modelPht[head.index] = stepCounter(head.counter, resolveTaken);
      end
      compareValue("mispredict", 32'(expMiss), 32'(mispredict));

      // Lookup hashes with the history from before this resolution
      doLookup = lookupValid && lookupReady;
      rdIndex  = modelHist ^ lookup.pc[`HIST_BITS:1];
      if (doLookup && credits == 0) begin
        reportFault("Lookup was accepted while the predictor held no credit");
      end
      if (doLookup && doResolve && head.index == rdIndex) begin
        forwards++;
      end

      // Entries shown this cycle reach the queue at the next edge
      if (pendValid) begin
        modelQueue.push_back(pendEntry);
      end
      pendValid         = doLookup;
      pendEntry.index   = rdIndex;
      pendEntry.counter = bpuCtrlPkg::counterState'(modelPht[rdIndex]);

      if (doResolve) begin
        modelHist = {resolveTaken, modelHist[`HIST_BITS-1:1]};
      end
      // A popped entry gives its credit back one cycle later
      if (doLookup) begin
        credits--;
      end
      if (creditDue) begin
        credits++;
      end
      creditDue = doResolve;

      outstanding = modelQueue.size();
      if (pendValid) begin
        outstanding++;
      end
      if (outstanding > `QUEUE_DEPTH) begin
        reportFault("Outstanding predictions exceed the queue depth");
      end
    end
  end

endmodule

//--- tests/bpuTb.sv
// Drives inputs 5 ns after each rising edge from a fixed LFSR seed; all comparing sits in bpuChecker
`timescale 1ns/1ps

module bpuTb;

  localparam int ResetCycles   = 8;
  localparam int StimCycles    = 2000;
  localparam int TimeoutCycles = StimCycles + 50;

  logic                 clk = 1'b0;
  logic                 rstN;
  logic                 lookupValid;
  bpuDataPkg::lookupReq lookup;
  logic                 lookupReady;
  logic                 predValid;
  bpuDataPkg::predEntry predOut;
  logic                 resolveValid;
  logic                 resolveTaken;
  logic                 resolveReady;
  logic                 mispredict;
  logic [15:0]          lfsr;
  logic [7:0]           draw;
  int                   cycleCount = 0;
  int                   missCount = 0;
  int                   errorCount;
  int                   checkCount;
  int                   forwardCount;
  int                   satCount;

  // 100 ns period
  always #50 clk = ~clk;

  // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] nextLfsr(logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // One LFSR step per bit and the newest bit lands in bit 0
  task automatic drawBits(input int count);
    draw = '0;
    for (int k = 0; k < count; k++) begin
      lfsr = nextLfsr(lfsr);
      draw = {draw[6:0], lfsr[0]};
    end
  endtask

  // Four branches only, so indices alias often and forwarding gets exercised
  function automatic logic [31:0] poolPc(logic [1:0] sel);
    case (sel)
      2'd0:    return 32'h0040_1000;
      2'd1:    return 32'h0040_1008;
      2'd2:    return 32'h0040_1010;
      default: return 32'h0040_2004;
    endcase
  endfunction

  bpuTop UUT (
    .clk          (clk),
    .rstN         (rstN),
    .lookupValid  (lookupValid),
    .lookup       (lookup),
    .lookupReady  (lookupReady),
    .predValid    (predValid),
    .predOut      (predOut),
    .resolveValid (resolveValid),
    .resolveTaken (resolveTaken),
    .resolveReady (resolveReady),
    .mispredict   (mispredict)
  );

  bpuChecker scoreboard (
    .clk          (clk),
    .rstN         (rstN),
    .lookupValid  (lookupValid),
    .lookup       (lookup),
    .lookupReady  (lookupReady),
    .predValid    (predValid),
    .predOut      (predOut),
    .resolveValid (resolveValid),
    .resolveTaken (resolveTaken),
    .resolveReady (resolveReady),
    .mispredict   (mispredict),
    .errorCount   (errorCount),
    .checkCount   (checkCount),
    .forwardCount (forwardCount),
    .satCount     (satCount)
  );

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    rstN         = 1'b0;
    lookupValid  = 1'b0;
    lookup       = '0;
    resolveValid = 1'b0;
    resolveTaken = 1'b0;
    lfsr         = 16'd50101;
    repeat (ResetCycles) @(posedge clk);
    #5 rstN = 1'b1;
    for (int i = 0; i < StimCycles; i++) begin
      @(posedge clk);
      #5;
      // Lookups three times in four are enough to run out of credits
      drawBits(2);
      lookupValid = (draw[1:0] != 2'b00);
      drawBits(2);
      lookup.pc = poolPc(draw[1:0]);
      drawBits(1);
      resolveValid = draw[0];
      // Mostly taken so counters pin at strongTaken and history repeats
      drawBits(3);
      resolveTaken = (draw[2:0] != 3'b000);
    end
    @(posedge clk);
    #5;
    lookupValid  = 1'b0;
    resolveValid = 1'b0;
    repeat (3) @(posedge clk);
    #10;
    // A run that never reaches forwarding or saturation leaves those paths untested
    if (forwardCount == 0) begin
      $display("Write forwarding was never exercised by the stimulus");
      missCount++;
    end
    if (satCount == 0) begin
      $display("No counter was ever pushed against its saturation limit");
      missCount++;
    end
    $display("Checks %0d, errors %0d, forwarding hits %0d, saturating updates %0d",
             checkCount, errorCount + missCount, forwardCount, satCount);
    if (errorCount + missCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Guard against a stuck run
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycleCount);
      $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

//--- filelist.f
+incdir+include
design/bpuCtrlPkg.sv
design/bpuDataPkg.sv
design/phtRam.sv
design/gshareLookup.sv
design/predictionQueue.sv
design/branchResolver.sv
design/bpuTop.sv
tests/bpuChecker.sv
tests/bpuTb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing -f filelist.f --top-module bpuTb -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/VbpuTb > sim.log 2>&1 \
  || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "ERRORS FOUND" sim.log && { echo "Simulation reported errors"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }
